//--- design/fetch_pkg.sv
//****************************************
// Shared types for the fetch front end
// Addresses are 40-bit virtual, no compressed instructions
// Cause codes follow the RISC-V mcause numbering where one exists
//****************************************

package fetch_pkg;

    // Virtual address and raw instruction word
    typedef logic [39:0] addr_t;
    typedef logic [31:0] inst_t;

    // Boot address and base of the instruction ROM
    localparam addr_t RESET_PC = 40'h1000;

    // Only opcode the decoder understands
    localparam logic [6:0] OPCODE_JAL = 7'h6f;

    // Next PC source in order of rising priority
    typedef enum logic [1:0] {
        SEL_PC,
        SEL_PC_4,
        SEL_REDIRECT,
        SEL_COMMIT
    } next_pc_sel_t;

    // Misaligned fetch is mcause 0, so "none" takes an unused code
    typedef enum logic [3:0] {
        MISALIGNED_FETCH = 4'h0,
        NO_EXC           = 4'hf
    } exc_cause_t;

    // Four-phase request towards the instruction memory
    typedef struct packed {
        logic  req;
        addr_t vaddr;
    } icache_req_t;

    // Four-phase answer with data valid while ack is high
    typedef struct packed {
        logic  ack;
        inst_t data;
    } icache_resp_t;

    // Queue payload produced by the PC generator
    typedef struct packed {
        addr_t      pc;
        inst_t      inst;
        logic       ex_valid;
        exc_cause_t ex_cause;
    } fetch_entry_t;

    // Decoded entry offered to the backend
    typedef struct packed {
        addr_t      pc;
        inst_t      inst;
        logic [4:0] rd;
        logic       is_jal;
        addr_t      target;
        exc_cause_t ex_cause;
    } decode_entry_t;

endpackage

//--- design/pc_gen.sv
//****************************************
// PC generator with a four-phase fetch request
// One request in flight at a time
// Halts after a misaligned PC until a commit
//****************************************
`timescale 1ns/100ps

module pc_gen (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  fetch_pkg::icache_resp_t icache_resp_i,
    input  logic                    full_i,
    input  logic                    redirect_i,
    input  fetch_pkg::addr_t        redirect_pc_i,
    input  logic                    commit_valid_i,
    input  fetch_pkg::addr_t        pc_commit_i,
    output fetch_pkg::icache_req_t  icache_req_o,
    output logic                    push_o,
    output fetch_pkg::fetch_entry_t entry_o
);
    import fetch_pkg::*;

    // IDLE picks the next step, DRAIN waits for ack to fall
    typedef enum logic [2:0] {ST_IDLE, ST_REQ, ST_DRAIN, ST_PUSH, ST_HALT} state_t;

    state_t       state_q, state_d;
    next_pc_sel_t pc_sel;
    addr_t        pc_q, next_pc;
    addr_t        vaddr_q;
    fetch_entry_t entry_q;
    logic         discard_q;
    logic         steer;
    logic         misaligned;

    // Any change of fetch direction by commit or decode
    assign steer      = commit_valid_i | redirect_i;
    assign misaligned = |pc_q[1:0];

    // Push while the queue has room, flush in the same cycle wins
    assign push_o  = (state_q == ST_PUSH) && !full_i;
    assign entry_o = entry_q;

    // Request is high only in REQ, address held from launch
    assign icache_req_o.req   = (state_q == ST_REQ);
    assign icache_req_o.vaddr = vaddr_q;

    // Commit first, then decode redirect, then advance on a good push
    always_comb begin
        if (commit_valid_i) begin
            pc_sel = SEL_COMMIT;
        end else if (redirect_i) begin
            pc_sel = SEL_REDIRECT;
        end else if (push_o && !entry_q.ex_valid) begin
            pc_sel = SEL_PC_4;
        end else begin
            pc_sel = SEL_PC;
        end
    end

    always_comb begin
        unique case (pc_sel)
            SEL_PC:       next_pc = pc_q;
            SEL_PC_4:     next_pc = pc_q + 40'h4;
            SEL_REDIRECT: next_pc = redirect_pc_i;
            SEL_COMMIT:   next_pc = pc_commit_i;
            default:      next_pc = pc_q;
        endcase
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            // Bad PC skips the cache and queues an exception
            ST_IDLE:  if (!steer) state_d = misaligned ? ST_PUSH : ST_REQ;
            ST_REQ:   if (icache_resp_i.ack) state_d = ST_DRAIN;
            // Stale data is dropped once the handshake closes
            ST_DRAIN: begin
                if (!icache_resp_i.ack) begin
                    state_d = (discard_q || steer) ? ST_IDLE : ST_PUSH;
                end
            end
            ST_PUSH: begin
                if (steer) begin
                    state_d = ST_IDLE;
                end else if (!full_i) begin
                    state_d = entry_q.ex_valid ? ST_HALT : ST_IDLE;
                end
            end
            ST_HALT:  if (commit_valid_i) state_d = ST_IDLE;
            default:  state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q   <= ST_IDLE;
            pc_q      <= RESET_PC;
            discard_q <= 1'b0;
        end else begin
            state_q <= state_d;
            pc_q    <= next_pc;
            // Remember a redirect that hit an open handshake
            if ((state_q == ST_DRAIN) && !icache_resp_i.ack) begin
                discard_q <= 1'b0;
            end else if ((state_q == ST_REQ || state_q == ST_DRAIN) && steer) begin
                discard_q <= 1'b1;
            end
        end
    end

    // Launch address and the entry waiting for the queue
    always_ff @(posedge clk_i) begin
        if ((state_q == ST_IDLE) && !steer) begin
            if (misaligned) begin
                entry_q <= '{pc: pc_q, inst: '0, ex_valid: 1'b1, ex_cause: MISALIGNED_FETCH};
            end else begin
                vaddr_q <= pc_q;
            end
        end
        if ((state_q == ST_REQ) && icache_resp_i.ack) begin
            entry_q <= '{pc: vaddr_q, inst: icache_resp_i.data, ex_valid: 1'b0,
                         ex_cause: NO_EXC};
        end
    end

endmodule

//--- design/icache_rom.sv
//****************************************
// Instruction ROM with a four-phase port
// Contents come from program.hex in the run directory
// ROM_DELAY must be at least 1
//****************************************
`timescale 1ns/100ps

module icache_rom #(
    parameter int ROM_WORDS = 64,
    parameter int ROM_DELAY = 1
) (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  fetch_pkg::icache_req_t  req_i,
    output fetch_pkg::icache_resp_t resp_o
);
    import fetch_pkg::*;

    localparam int IDX_W = (ROM_WORDS > 1) ? $clog2(ROM_WORDS) : 1;
    localparam int CNT_W = (ROM_DELAY > 1) ? $clog2(ROM_DELAY) : 1;

    inst_t            mem [ROM_WORDS];
    addr_t            word_off;
    logic [IDX_W-1:0] word_idx;
    logic [CNT_W-1:0] delay_q;
    logic             ack_q;
    logic             fire;
    inst_t            data_q;

    initial begin
        $readmemh("program.hex", mem);
    end

    // Word offset from the boot address wrapped over the ROM
    assign word_off = (req_i.vaddr - RESET_PC) >> 2;
    assign word_idx = IDX_W'(word_off % addr_t'(ROM_WORDS));

    // Last wait cycle of an open request
    assign fire = req_i.req && !ack_q && (delay_q == CNT_W'(ROM_DELAY - 1));

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ack_q   <= 1'b0;
            delay_q <= '0;
        end else if (fire) begin
            ack_q   <= 1'b1;
            delay_q <= '0;
        end else if (req_i.req && !ack_q) begin
            delay_q <= delay_q + 1'b1;
        end else if (!req_i.req && ack_q) begin
            // Requester closed the handshake
            ack_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fire) data_q <= mem[word_idx];
    end

    assign resp_o.ack  = ack_q;
    assign resp_o.data = data_q;

endmodule

//--- design/fetch_queue.sv
//****************************************
// Circular FIFO with single-cycle push and pop
// Push when full and pop when empty are ignored
// Flush wins over a push in the same cycle
//****************************************
`timescale 1ns/100ps

module fetch_queue #(
    parameter type payload_t   = logic [31:0],
    parameter int  QUEUE_DEPTH = 4
) (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  logic     push_i,
    input  payload_t data_i,
    input  logic     pop_i,
    input  logic     flush_i,
    output payload_t head_o,
    output logic     full_o,
    output logic     empty_o
);
    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;

    payload_t         mem [QUEUE_DEPTH];
    ptr_t             rd_ptr_q, wr_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push, do_pop;

    // Wrap at the depth, which need not be a power of two
    function automatic ptr_t ptr_inc(ptr_t p);
        ptr_t n;
        if (p == ptr_t'(QUEUE_DEPTH - 1)) n = '0;
        else n = p + 1'b1;
        return n;
    endfunction

    assign full_o  = (count_q == CNT_W'(QUEUE_DEPTH));
    assign empty_o = (count_q == '0);
    assign head_o  = mem[rd_ptr_q];

    assign do_push = push_i && !full_o && !flush_i;
    assign do_pop  = pop_i && !empty_o && !flush_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (do_pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
            // Simultaneous push and pop keep the count
            if (do_push && !do_pop) count_q <= count_q + 1'b1;
            else if (do_pop && !do_push) count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) mem[wr_ptr_q] <= data_i;
    end

endmodule

//--- design/decode_stage.sv
//****************************************
// Decode of rd and JAL, four-phase output
// Redirect is a pulse in the pop cycle
// One entry in flight towards the backend
//****************************************
`timescale 1ns/100ps

module decode_stage (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  fetch_pkg::fetch_entry_t  head_i,
    input  logic                     empty_i,
    input  logic                     out_ack_i,
    output logic                     pop_o,
    output logic                     redirect_o,
    output fetch_pkg::addr_t         redirect_pc_o,
    output logic                     out_req_o,
    output fetch_pkg::decode_entry_t out_o
);
    import fetch_pkg::*;

    addr_t         j_imm;
    addr_t         jal_target;
    logic          is_jal;
    decode_entry_t dec;
    logic          req_q;
    decode_entry_t out_q;

    // J-type immediate sign-extended to the address width
    assign j_imm = {{19{head_i.inst[31]}}, head_i.inst[31], head_i.inst[19:12],
                    head_i.inst[20], head_i.inst[30:21], 1'b0};
    assign jal_target = head_i.pc + j_imm;

    // Exception entries carry a zero word, never a jump
    assign is_jal = !head_i.ex_valid && (head_i.inst[6:0] == OPCODE_JAL);

    always_comb begin
        dec.pc       = head_i.pc;
        dec.inst     = head_i.inst;
        dec.rd       = head_i.inst[11:7];
        dec.is_jal   = is_jal;
        // Fall-through for anything but a JAL
        dec.target   = is_jal ? jal_target : head_i.pc + 40'h4;
        dec.ex_cause = head_i.ex_valid ? head_i.ex_cause : NO_EXC;
    end

    // Take the head only once the previous ack has dropped
    assign pop_o = !req_q && !empty_i && !out_ack_i;

    // Fetch restarts at the jump target
    assign redirect_o    = pop_o && is_jal;
    assign redirect_pc_o = jal_target;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            req_q <= 1'b0;
        end else if (pop_o) begin
            req_q <= 1'b1;
        end else if (req_q && out_ack_i) begin
            // Backend took it, wait for ack low before the next
            req_q <= 1'b0;
        end
    end

    // Held stable while the request is open
    always_ff @(posedge clk_i) begin
        if (pop_o) out_q <= dec;
    end

    assign out_req_o = req_q;
    assign out_o     = out_q;

endmodule

//--- design/frontend_top.sv
//****************************************
// Fetch front end, PC to decoded entry
// Commit and decode redirect both flush the queue
//****************************************
`timescale 1ns/100ps

module frontend_top #(
    parameter int QUEUE_DEPTH = 4,
    parameter int ROM_WORDS   = 64,
    parameter int ROM_DELAY   = 1
) (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  logic                     commit_valid_i,
    input  fetch_pkg::addr_t         pc_commit_i,
    input  logic                     out_ack_i,
    output logic                     out_req_o,
    output fetch_pkg::decode_entry_t out_o
);
    import fetch_pkg::*;

    icache_req_t  icache_req;
    icache_resp_t icache_resp;
    fetch_entry_t push_entry, head_entry;
    logic         push, pop, full, empty;
    logic         redirect, flush;
    addr_t        redirect_pc;

    // Any redirect empties the queue in the same cycle
    assign flush = redirect | commit_valid_i;

    pc_gen u_pc_gen (
        .clk_i, .rstn_i, .icache_resp_i(icache_resp), .full_i(full),
        .redirect_i(redirect), .redirect_pc_i(redirect_pc), .commit_valid_i, .pc_commit_i,
        .icache_req_o(icache_req), .push_o(push), .entry_o(push_entry)
    );

    icache_rom #(.ROM_WORDS(ROM_WORDS), .ROM_DELAY(ROM_DELAY)) u_icache_rom (
        .clk_i, .rstn_i, .req_i(icache_req), .resp_o(icache_resp)
    );

    fetch_queue #(.payload_t(fetch_entry_t), .QUEUE_DEPTH(QUEUE_DEPTH)) u_fetch_queue (
        .clk_i, .rstn_i, .push_i(push), .data_i(push_entry), .pop_i(pop), .flush_i(flush),
        .head_o(head_entry), .full_o(full), .empty_o(empty)
    );

    decode_stage u_decode_stage (
        .clk_i, .rstn_i, .head_i(head_entry), .empty_i(empty), .out_ack_i,
        .pop_o(pop), .redirect_o(redirect), .redirect_pc_o(redirect_pc),
        .out_req_o, .out_o
    );

endmodule

//--- bench/frontend_tb.sv
//****************************************
// Testbench for the fetch front end
// Runs from bench/ so the ROM finds program.hex
// PROG_COPY has to match program.hex word for word
// Expects default top parameters, ROM_WORDS of 64
//****************************************
`timescale 1ns/100ps

module frontend_tb;
    import fetch_pkg::*;

    localparam int ROM_WORDS  = 64;
    localparam int PROG_LEN   = 18;
    localparam int WAIT_LIMIT = 200;

    // Reference copy of the ROM image
    localparam logic [31:0] PROG_COPY [PROG_LEN] = '{
        32'h00100093, 32'h00200113, 32'h00300193, 32'h00c002ef,
        32'h00400213, 32'h00500213, 32'h00600313, 32'h00700393,
        32'h006000ef, 32'h00900493, 32'h00a00513, 32'h00b00593,
        32'h00c00613, 32'h00000013, 32'h00000013, 32'h00000013,
        32'h00000013, 32'h00000013
    };

    logic          clk_i;
    logic          rstn_i;
    logic          commit_valid_i;
    addr_t         pc_commit_i;
    logic          out_ack_i;
    logic          out_req_o;
    decode_entry_t out_o;

    // Reference model state
    addr_t         exp_pc;
    decode_entry_t exp_entry;
    decode_entry_t held_entry;
    logic          halted;
    logic          offered;
    int            check_errors;
    int            timeouts;

    frontend_top dut0 (
        .clk_i, .rstn_i, .commit_valid_i, .pc_commit_i, .out_ack_i, .out_req_o, .out_o
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // Words past the end of the program read as zero
    function automatic logic [31:0] prog_word(addr_t pc);
        addr_t idx;
        idx = ((pc - RESET_PC) >> 2) % addr_t'(ROM_WORDS);
        if (idx >= addr_t'(PROG_LEN)) return 32'h0;
        return PROG_COPY[idx[4:0]];
    endfunction

    function automatic decode_entry_t expected_entry(addr_t pc);
        decode_entry_t e;
        logic [31:0]   w;
        logic [20:0]   imm;
        w   = prog_word(pc);
        // J-immediate with bit 0 always zero
        imm = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        e.pc       = pc;
        e.inst     = w;
        e.rd       = w[11:7];
        e.is_jal   = (w[6:0] == 7'h6f);
        e.target   = pc + {{19{imm[20]}}, imm};
        e.ex_cause = NO_EXC;
        if (pc[1:0] != 2'b00) begin
            // Misaligned PC never reaches the ROM
            e.inst     = '0;
            e.rd       = '0;
            e.is_jal   = 1'b0;
            e.target   = '0;
            e.ex_cause = MISALIGNED_FETCH;
        end
        return e;
    endfunction

    function automatic addr_t next_pc_after(addr_t pc);
        decode_entry_t e;
        e = expected_entry(pc);
        return e.is_jal ? e.target : pc + 40'h4;
    endfunction

    assign exp_entry = expected_entry(exp_pc);
    assign offered   = out_req_o && !out_ack_i;

    task automatic report_mismatch(input string name, input logic [127:0] expected,
                                   input logic [127:0] actual);
        check_errors = check_errors + 1;
        $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
    endtask

    a_reset_idle: assert property (@(posedge clk_i) !rstn_i |-> !out_req_o)
        else report_mismatch("reset_idle", 128'd0, 128'd1);
    // Entry content while the backend has not acked it yet
    a_pc_order: assert property (@(posedge clk_i) disable iff (!rstn_i)
        offered |-> out_o.pc == exp_entry.pc)
        else report_mismatch("pc_order", 128'($sampled(exp_entry.pc)), 128'($sampled(out_o.pc)));
    a_inst_word: assert property (@(posedge clk_i) disable iff (!rstn_i)
        offered |-> out_o.inst == exp_entry.inst)
        else report_mismatch("inst_word", 128'($sampled(exp_entry.inst)),
                             128'($sampled(out_o.inst)));
    a_rd_field: assert property (@(posedge clk_i) disable iff (!rstn_i)
        offered |-> out_o.rd == exp_entry.rd)
        else report_mismatch("rd_field", 128'($sampled(exp_entry.rd)), 128'($sampled(out_o.rd)));
    a_jal_flag: assert property (@(posedge clk_i) disable iff (!rstn_i)
        offered |-> out_o.is_jal == exp_entry.is_jal)
        else report_mismatch("jal_flag", 128'($sampled(exp_entry.is_jal)),
                             128'($sampled(out_o.is_jal)));
    a_jal_target: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (offered && exp_entry.is_jal) |-> out_o.target == exp_entry.target)
        else report_mismatch("jal_target", 128'($sampled(exp_entry.target)),
                             128'($sampled(out_o.target)));
    a_exc_cause: assert property (@(posedge clk_i) disable iff (!rstn_i)
        offered |-> out_o.ex_cause == exp_entry.ex_cause)
        else report_mismatch("exc_cause", 128'($sampled(exp_entry.ex_cause)),
                             128'($sampled(out_o.ex_cause)));
    // Fetch stays quiet after a misaligned entry until the commit
    a_halt_quiet: assert property (@(posedge clk_i) disable iff (!rstn_i)
        halted |-> !out_req_o)
        else report_mismatch("halt_quiet", 128'd0, 128'd1);
    a_backpressure_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        offered |=> out_o == held_entry)
        else report_mismatch("backpressure_hold", 128'($sampled(held_entry)),
                             128'($sampled(out_o)));
    a_req_fall: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $fell(out_req_o) |-> $past(out_ack_i))
        else report_mismatch("req_fall", 128'd1, 128'd0);
    a_req_rise: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $rose(out_req_o) |-> !$past(out_ack_i))
        else report_mismatch("req_rise", 128'd0, 128'd1);

    task automatic finish_run();
        $display("Error count: %0d failed checks, %0d timeouts", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    task automatic wait_out_req(input logic level);
        int cycles;
        cycles = 0;
        @(posedge clk_i);
        while (out_req_o !== level && cycles < WAIT_LIMIT) begin
            @(posedge clk_i);
            cycles++;
        end
        if (out_req_o !== level) begin
            timeouts = timeouts + 1;
            $display("Timeout: out_req_o did not reach %0b within %0d cycles", level, WAIT_LIMIT);
        end
    endtask

    // Backend side of one four-phase transfer with an optional commit at the ack
    task automatic accept_entry(input int hold, input logic commit, input addr_t commit_pc);
        logic was_exc;
        was_exc = (exp_pc[1:0] != 2'b00);
        // Nothing more to drive once a wait has run out
        if (timeouts != 0) return;
        wait_out_req(1'b1);
        if (timeouts != 0) return;
        held_entry = out_o;
        repeat (hold) @(posedge clk_i);
        out_ack_i <= 1'b1;
        if (commit) begin
            commit_valid_i <= 1'b1;
            pc_commit_i    <= commit_pc;
            exp_pc         <= commit_pc;
        end else begin
            exp_pc <= next_pc_after(exp_pc);
        end
        @(posedge clk_i);
        commit_valid_i <= 1'b0;
        wait_out_req(1'b0);
        out_ack_i <= 1'b0;
        if (was_exc) halted <= 1'b1;
    endtask

    task automatic pulse_commit(input addr_t pc);
        commit_valid_i <= 1'b1;
        pc_commit_i    <= pc;
        exp_pc         <= pc;
        halted         <= 1'b0;
        @(posedge clk_i);
        commit_valid_i <= 1'b0;
    endtask

    initial begin
        int hold;
        void'($urandom(32'hf9efcd56));
        rstn_i         = 1'b0;
        commit_valid_i = 1'b0;
        pc_commit_i    = '0;
        out_ack_i      = 1'b0;
        exp_pc         = RESET_PC;
        held_entry     = '0;
        halted         = 1'b0;
        check_errors   = 0;
        timeouts       = 0;
        repeat (2) @(posedge clk_i);
        rstn_i <= 1'b1;
        // Sequential words, JAL +12, then the misaligned JAL and its exception
        for (int i = 0; i < 8; i++) begin
            hold = (i % 3 == 2) ? int'($urandom_range(40, 5)) : int'($urandom_range(2, 0));
            accept_entry(hold, 1'b0, '0);
        end
        repeat (30) @(posedge clk_i);
        // Resume just past the misaligned jump
        pulse_commit(RESET_PC + 40'h24);
        accept_entry(3, 1'b0, '0);
        // Long stall fills the queue, then commit back to the boot address
        accept_entry(int'($urandom_range(40, 5)), 1'b1, RESET_PC);
        for (int i = 0; i < 8; i++) begin
            hold = (i % 2 == 1) ? int'($urandom_range(40, 5)) : 0;
            accept_entry(hold, 1'b0, '0);
        end
        repeat (20) @(posedge clk_i);
        finish_run();
    end

endmodule

//--- src.f
design/fetch_pkg.sv
design/pc_gen.sv
design/icache_rom.sv
design/fetch_queue.sv
design/decode_stage.sv
design/frontend_top.sv
bench/frontend_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the fetch front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module frontend_tb -Mdir obj_dir

# The ROM loads program.hex from the working directory
(cd bench && ../obj_dir/Vfrontend_tb) > sim.log 2>&1
cat sim.log

if grep -q "Some tests failed" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation finished without failures"

//--- bench/program.hex
// One 32-bit instruction word per line, word n at address 0x1000 + 4*n
// Columns: instruction word in hex, addi filler with two JALs (+12 and a misaligned +6)
00100093
00200113
00300193
00c002ef
00400213
00500213
00600313
00700393
006000ef
00900493
00a00513
00b00593
00c00613
00000013
00000013
00000013
00000013
00000013
